/* video_pkg.sv */
`default_nettype none

package video_pkg;

    // camera and display data widths
    localparam int PIX_W  = 16;
    localparam int CH_W   = 8;
    localparam int PACK_W = 49;

    localparam int X_BITS = 11; // default coordinate widths.
    localparam int Y_BITS = 10;

    // pack word field positions from the lsb up
    localparam int HS_POS = 0;
    localparam int VS_POS = 1;
    localparam int DE_POS = 2;
    localparam int B_LSB  = 3;
    localparam int G_LSB  = 11;
    localparam int R_LSB  = 19;
    localparam int X_LSB  = 27;
    localparam int Y_LSB  = 38;
    localparam int FS_POS = 48; // frame start flag.

    // rgb565 fields inside the camera word
    localparam int PIX_R_LSB = 0;
    localparam int PIX_R_W   = 5;
    localparam int PIX_G_LSB = 5;
    localparam int PIX_G_W   = 6;
    localparam int PIX_B_LSB = 11;
    localparam int PIX_B_W   = 5;

endpackage : video_pkg

`default_nettype wire

/* sync_vg.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_vg #(
    parameter int H_FP    = 300,
    parameter int H_BP    = 300,
    parameter int H_SYNC  = 12,
    parameter int H_ACT   = 1280,
    parameter int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP,
    parameter int V_FP    = 7,
    parameter int V_BP    = 11,
    parameter int V_SYNC  = 2,
    parameter int V_ACT   = 720,
    parameter int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP,
    parameter int X_BITS  = video_pkg::X_BITS,
    parameter int Y_BITS  = video_pkg::Y_BITS
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_run,
    output logic              o_hs,
    output logic              o_vs,
    output logic              o_de,
    output logic [X_BITS-1:0] o_x,
    output logic [Y_BITS-1:0] o_y
);

    localparam int HC_W = $clog2(H_TOTAL);
    localparam int VC_W = $clog2(V_TOTAL);

    // region boundaries in counter width
    localparam logic [HC_W-1:0] H_LAST    = HC_W'(H_TOTAL - 1);
    localparam logic [HC_W-1:0] H_SYNC_END = HC_W'(H_SYNC);
    localparam logic [HC_W-1:0] H_START   = HC_W'(H_SYNC + H_BP);
    localparam logic [HC_W-1:0] H_END     = HC_W'(H_SYNC + H_BP + H_ACT);

    localparam logic [VC_W-1:0] V_LAST    = VC_W'(V_TOTAL - 1);
    localparam logic [VC_W-1:0] V_SYNC_END = VC_W'(V_SYNC);
    localparam logic [VC_W-1:0] V_START   = VC_W'(V_SYNC + V_BP);
    localparam logic [VC_W-1:0] V_END     = VC_W'(V_SYNC + V_BP + V_ACT);

    logic [HC_W-1:0] h_cnt;
    logic [VC_W-1:0] v_cnt;
    logic            h_wrap;
    logic            hs_d;
    logic            vs_d;
    logic            h_act;
    logic            v_act;
    logic            de_d;
    logic [HC_W-1:0] h_off;
    logic [VC_W-1:0] v_off;

    assign h_wrap = (h_cnt == H_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!i_run) begin
            h_cnt <= '0; // held until the first vsync.
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // region decode from the current counter state
    assign hs_d  = (h_cnt < H_SYNC_END);
    assign vs_d  = (v_cnt < V_SYNC_END);
    assign h_act = (h_cnt >= H_START) && (h_cnt < H_END);
    assign v_act = (v_cnt >= V_START) && (v_cnt < V_END);
    assign de_d  = h_act && v_act;
    assign h_off = h_cnt - H_START;
    assign v_off = v_cnt - V_START;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_hs <= 1'b0;
            o_vs <= 1'b0;
            o_de <= 1'b0;
            o_x  <= '0;
            o_y  <= '0;
        end else if (!i_run) begin
            o_hs <= 1'b0;
            o_vs <= 1'b0;
            o_de <= 1'b0;
            o_x  <= '0;
            o_y  <= '0;
        end else begin
            o_hs <= hs_d;
            o_vs <= vs_d;
            o_de <= de_d;
            o_x  <= de_d ? X_BITS'(h_off) : '0; // zero outside active.
            o_y  <= de_d ? Y_BITS'(v_off) : '0;
        end
    end

endmodule : sync_vg

`default_nettype wire

/* line_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
    parameter int DEPTH = 2048,
    parameter int PIX_W = video_pkg::PIX_W
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_wr,
    input  logic [PIX_W-1:0] i_wr_data,
    input  logic             i_rd,
    output logic [PIX_W-1:0] o_rd_data,
    output logic             o_underflow,
    output logic             o_overflow
);

    localparam int AW = $clog2(DEPTH);

    logic [PIX_W-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr; // extra msb tells full from empty.
    logic [AW:0]      rd_ptr;
    logic             empty;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ok = i_wr && !full;
    assign rd_ok = i_rd && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            o_underflow <= 1'b0;
            o_overflow  <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_wr && full) begin
                o_overflow <= 1'b1; // write dropped.
            end
            if (i_rd && empty) begin
                o_underflow <= 1'b1;
            end
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_data;
        end
        if (i_rd) begin
            o_rd_data <= empty ? '0 : mem[rd_ptr[AW-1:0]]; // empty read gives zero.
        end
    end

endmodule : line_fifo

`default_nettype wire

/* hdmi_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_pack #(
    parameter int X_BITS = video_pkg::X_BITS,
    parameter int Y_BITS = video_pkg::Y_BITS
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         i_hs,
    input  logic                         i_vs,
    input  logic                         i_de,
    input  logic [video_pkg::PIX_W-1:0]  i_pix,
    input  logic [X_BITS-1:0]            i_x,
    input  logic [Y_BITS-1:0]            i_y,
    output logic [video_pkg::PACK_W-1:0] o_pack
);

    import video_pkg::*;

    logic [CH_W-1:0]   r_exp;
    logic [CH_W-1:0]   g_exp;
    logic [CH_W-1:0]   b_exp;
    logic              fs;
    logic [PACK_W-1:0] pack_d;

    // rgb565 to 888 by zero fill at the low end
    assign r_exp = {i_pix[PIX_R_LSB +: PIX_R_W], {(CH_W - PIX_R_W){1'b0}}};
    assign g_exp = {i_pix[PIX_G_LSB +: PIX_G_W], {(CH_W - PIX_G_W){1'b0}}};
    assign b_exp = {i_pix[PIX_B_LSB +: PIX_B_W], {(CH_W - PIX_B_W){1'b0}}};

    assign fs = i_de && (i_x == '0) && (i_y == '0); // first active pixel.

    always_comb begin
        pack_d                    = '0;
        pack_d[HS_POS]            = i_hs;
        pack_d[VS_POS]            = i_vs;
        pack_d[DE_POS]            = i_de;
        pack_d[B_LSB +: CH_W]     = i_de ? b_exp : '0;
        pack_d[G_LSB +: CH_W]     = i_de ? g_exp : '0;
        pack_d[R_LSB +: CH_W]     = i_de ? r_exp : '0;
        pack_d[X_LSB +: X_BITS]   = i_x;
        pack_d[Y_LSB +: Y_BITS]   = i_y;
        pack_d[FS_POS]            = fs;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pack <= '0;
        end else begin
            o_pack <= pack_d;
        end
    end

endmodule : hdmi_pack

`default_nettype wire

/* hdmi_display.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_display #(
    parameter int H_FP       = 300,
    parameter int H_BP       = 300,
    parameter int H_SYNC     = 12,
    parameter int H_ACT      = 1280,
    parameter int H_TOTAL    = H_SYNC + H_BP + H_ACT + H_FP,
    parameter int V_FP       = 7,
    parameter int V_BP       = 11,
    parameter int V_SYNC     = 2,
    parameter int V_ACT      = 720,
    parameter int V_TOTAL    = V_SYNC + V_BP + V_ACT + V_FP,
    parameter int FIFO_DEPTH = 2048,
    parameter int X_BITS     = video_pkg::X_BITS,
    parameter int Y_BITS     = video_pkg::Y_BITS
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         i_vsync,
    input  logic                         i_href,
    input  logic [video_pkg::PIX_W-1:0]  i_data,
    output logic [video_pkg::PACK_W-1:0] o_pack,
    output logic                         o_underflow,
    output logic                         o_overflow
);

    import video_pkg::*;

    logic              vsync_d;
    logic              run;
    logic              vg_hs;
    logic              vg_vs;
    logic              vg_de;
    logic [X_BITS-1:0] vg_x;
    logic [Y_BITS-1:0] vg_y;
    logic              hs_d;
    logic              vs_d;
    logic              de_d;
    logic [X_BITS-1:0] x_d;
    logic [Y_BITS-1:0] y_d;
    logic [PIX_W-1:0]  rd_pix;

    // run latches on the first vsync rise and stays set
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b1; // a low level must be seen first.
            run     <= 1'b0;
        end else begin
            vsync_d <= i_vsync;
            if (!vsync_d && i_vsync) begin
                run <= 1'b1;
            end
        end
    end

    sync_vg #(
        .H_FP   (H_FP),
        .H_BP   (H_BP),
        .H_SYNC (H_SYNC),
        .H_ACT  (H_ACT),
        .H_TOTAL(H_TOTAL),
        .V_FP   (V_FP),
        .V_BP   (V_BP),
        .V_SYNC (V_SYNC),
        .V_ACT  (V_ACT),
        .V_TOTAL(V_TOTAL),
        .X_BITS (X_BITS),
        .Y_BITS (Y_BITS)
    ) u_sync_vg (
        .clk  (clk),
        .rstn (rstn),
        .i_run(run),
        .o_hs (vg_hs),
        .o_vs (vg_vs),
        .o_de (vg_de),
        .o_x  (vg_x),
        .o_y  (vg_y)
    );

    line_fifo #(
        .DEPTH(FIFO_DEPTH),
        .PIX_W(PIX_W)
    ) u_line_fifo (
        .clk        (clk),
        .rstn       (rstn),
        .i_wr       (i_href),
        .i_wr_data  (i_data),
        .i_rd       (vg_de),
        .o_rd_data  (rd_pix),
        .o_underflow(o_underflow),
        .o_overflow (o_overflow)
    );

    // line timing up with the fifo read data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hs_d <= 1'b0;
            vs_d <= 1'b0;
            de_d <= 1'b0;
            x_d  <= '0;
            y_d  <= '0;
        end else begin
            hs_d <= vg_hs;
            vs_d <= vg_vs;
            de_d <= vg_de;
            x_d  <= vg_x;
            y_d  <= vg_y;
        end
    end

    hdmi_pack #(
        .X_BITS(X_BITS),
        .Y_BITS(Y_BITS)
    ) u_disp_pack (
        .clk   (clk),
        .rstn  (rstn),
        .i_hs  (hs_d),
        .i_vs  (vs_d),
        .i_de  (de_d),
        .i_pix (rd_pix),
        .i_x   (x_d),
        .i_y   (y_d),
        .o_pack(o_pack)
    );

endmodule : hdmi_display

`default_nettype wire

/* tb_hdmi_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_display;

    import video_pkg::*;

    localparam int H_SYNC      = 2;
    localparam int H_BP        = 3;
    localparam int H_ACT       = 8;
    localparam int H_FP        = 3;
    localparam int H_TOTAL     = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_SYNC      = 1;
    localparam int V_BP        = 2;
    localparam int V_ACT       = 4;
    localparam int V_FP        = 1;
    localparam int V_TOTAL     = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int FIFO_DEPTH  = 16;
    localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYC = 4 * FRAME_CYC + 200;
    localparam int FRAME_PIX   = H_ACT * V_ACT;
    localparam int TOTAL_PIX   = 2 * FRAME_PIX; // camera feeds two frames.
    localparam int PREFILL     = 6;
    localparam int RUN_FRAMES  = 3;

    logic              clk;
    logic              rstn;
    logic              i_vsync;
    logic              i_href;
    logic [PIX_W-1:0]  i_data;
    logic [PACK_W-1:0] o_pack;
    logic              o_underflow;
    logic              o_overflow;

    logic              pk_hs;
    logic              pk_vs;
    logic              pk_de;
    logic              pk_fs;
    logic [CH_W-1:0]   pk_r;
    logic [CH_W-1:0]   pk_g;
    logic [CH_W-1:0]   pk_b;
    logic [X_BITS-1:0] pk_x;
    logic [Y_BITS-1:0] pk_y;

    logic [PIX_W-1:0]  exp_q[$]; // pixels written but not yet seen.
    integer            seed      = 14454;
    int                written   = 0;
    int                cycle_cnt = 0;
    logic              started   = 1'b0;
    logic              done      = 1'b0;

    int                hpos       = 0;
    int                hs_len     = 0;
    int                vs_len     = 0;
    int                de_len     = 0;
    int                lines_de   = 0;
    int                cur_y      = 0;
    int                frames     = 0;
    int                zero_pix   = 0;
    logic              line_seen  = 1'b0;
    logic              frame_seen = 1'b0;
    logic              uf_seen    = 1'b0;
    logic              prev_hs    = 1'b0;
    logic              prev_vs    = 1'b0;
    logic              prev_de    = 1'b0;

    hdmi_display #(
        .H_FP      (H_FP),
        .H_BP      (H_BP),
        .H_SYNC    (H_SYNC),
        .H_ACT     (H_ACT),
        .H_TOTAL   (H_TOTAL),
        .V_FP      (V_FP),
        .V_BP      (V_BP),
        .V_SYNC    (V_SYNC),
        .V_ACT     (V_ACT),
        .V_TOTAL   (V_TOTAL),
        .FIFO_DEPTH(FIFO_DEPTH),
        .X_BITS    (X_BITS),
        .Y_BITS    (Y_BITS)
    ) dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .i_vsync    (i_vsync),
        .i_href     (i_href),
        .i_data     (i_data),
        .o_pack     (o_pack),
        .o_underflow(o_underflow),
        .o_overflow (o_overflow)
    );

    assign pk_hs = o_pack[HS_POS];
    assign pk_vs = o_pack[VS_POS];
    assign pk_de = o_pack[DE_POS];
    assign pk_fs = o_pack[FS_POS];
    assign pk_r  = o_pack[R_LSB +: CH_W];
    assign pk_g  = o_pack[G_LSB +: CH_W];
    assign pk_b  = o_pack[B_LSB +: CH_W];
    assign pk_x  = o_pack[X_LSB +: X_BITS];
    assign pk_y  = o_pack[Y_LSB +: Y_BITS];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // red sits in the low bits of the camera word, blue in the high bits
    function automatic logic [23:0] expand_565(input logic [PIX_W-1:0] pix);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = {pix[4:0], 3'b000};
        g = {pix[10:5], 2'b00};
        b = {pix[15:11], 3'b000};
        return {r, g, b};
    endfunction

    task automatic push_pixel();
        logic [PIX_W-1:0] pix;
        pix = PIX_W'($random(seed));
        i_href <= 1'b1;
        i_data <= pix;
        exp_q.push_back(pix);
        written++;
    endtask

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    initial begin : stimulus
        logic end_ok;
        rstn    = 1'b0;
        i_vsync = 1'b0;
        i_href  = 1'b0;
        i_data  = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (16) @(posedge clk);
        repeat (PREFILL) begin
            @(posedge clk);
            push_pixel(); // fifo runs a few pixels ahead of the display.
        end
        @(posedge clk);
        i_href  <= 1'b0;
        i_vsync <= 1'b1;
        started <= 1'b1;
        repeat (2) @(posedge clk);
        i_vsync <= 1'b0;
        while (written < TOTAL_PIX) begin
            @(posedge clk);
            if (pk_de) begin
                push_pixel(); // one write per displayed pixel.
            end else begin
                i_href <= 1'b0;
            end
        end
        @(posedge clk);
        i_href <= 1'b0;
        wait (done);
        @(posedge clk);
        end_ok = (exp_q.size() == 0) && (zero_pix == FRAME_PIX) && uf_seen;
        if (end_ok) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("run ended with camera pixels left over or no underflow frame seen");
            $display("TEST FAIL");
            $fatal(1, "end of run checks failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            report_problem("timeout: the display did not finish its frames in time");
        end
    end

    always @(posedge clk) begin : check_pack
        logic [PIX_W-1:0] pix;
        logic [23:0]      exp_rgb;
        logic             exp_fs;
        if (rstn) begin
            if (!started) begin
                assert (o_pack == '0) else report_mismatch("o_pack", o_pack, 0);
                assert (!o_underflow) else report_mismatch("o_underflow", o_underflow, 0);
            end
            assert (!o_overflow) else report_mismatch("o_overflow", o_overflow, 0);
            if (uf_seen) begin
                assert (o_underflow) else report_mismatch("o_underflow", o_underflow, 1);
            end
            uf_seen = uf_seen | o_underflow;

            if (pk_hs && !prev_hs) begin
                if (line_seen) begin
                    assert (hpos + 1 == H_TOTAL)
                        else report_mismatch("hs period", hpos + 1, H_TOTAL);
                end
                line_seen = 1'b1;
                hpos      = 0;
            end else begin
                hpos++;
            end
            if (pk_hs) begin
                hs_len++;
            end else if (prev_hs) begin
                assert (hs_len == H_SYNC) else report_mismatch("hs width", hs_len, H_SYNC);
                hs_len = 0;
            end

            if (pk_vs && !prev_vs) begin
                if (frame_seen) begin
                    assert (lines_de == V_ACT)
                        else report_mismatch("de lines", lines_de, V_ACT);
                    frames++;
                    if (frames == RUN_FRAMES) begin
                        done <= 1'b1;
                    end
                end
                frame_seen = 1'b1;
                lines_de   = 0;
            end
            if (pk_vs) begin
                vs_len++;
            end else if (prev_vs) begin
                assert (vs_len == V_SYNC * H_TOTAL)
                    else report_mismatch("vs width", vs_len, V_SYNC * H_TOTAL);
                vs_len = 0;
            end

            exp_fs = 1'b0;
            if (pk_de) begin
                if (!prev_de) begin
                    assert (hpos == H_SYNC + H_BP)
                        else report_mismatch("de start", hpos, H_SYNC + H_BP);
                    cur_y  = lines_de;
                    de_len = 0;
                    lines_de++;
                end
                exp_fs = (de_len == 0) && (cur_y == 0);
                assert (pk_x == X_BITS'(de_len)) else report_mismatch("x", pk_x, de_len);
                assert (pk_y == Y_BITS'(cur_y)) else report_mismatch("y", pk_y, cur_y);
                de_len++;
                if (exp_q.size() > 0) begin
                    pix     = exp_q.pop_front();
                    exp_rgb = expand_565(pix);
                    assert ({pk_r, pk_g, pk_b} == exp_rgb)
                        else report_mismatch("rgb", {pk_r, pk_g, pk_b}, exp_rgb);
                    if (frames < 2) begin
                        assert (!o_underflow)
                            else report_mismatch("o_underflow", o_underflow, 0);
                    end
                end else begin
                    if (frames < 2) begin
                        report_problem("camera pixels ran out before the third frame");
                    end
                    assert ({pk_r, pk_g, pk_b} == 24'h0)
                        else report_mismatch("rgb", {pk_r, pk_g, pk_b}, 0);
                    assert (o_underflow) else report_mismatch("o_underflow", o_underflow, 1);
                    zero_pix++;
                end
            end else begin
                if (prev_de) begin
                    assert (de_len == H_ACT) else report_mismatch("de length", de_len, H_ACT);
                end
                assert (pk_x == '0) else report_mismatch("x", pk_x, 0);
                assert (pk_y == '0) else report_mismatch("y", pk_y, 0);
                assert ({pk_r, pk_g, pk_b} == 24'h0)
                    else report_mismatch("rgb", {pk_r, pk_g, pk_b}, 0);
            end
            assert (pk_fs == exp_fs) else report_mismatch("frame start", pk_fs, exp_fs);

            prev_hs = pk_hs;
            prev_vs = pk_vs;
            prev_de = pk_de;
        end
    end

endmodule : tb_hdmi_display

`default_nettype wire

/* sources.f */
video_pkg.sv
sync_vg.sv
line_fifo.sv
hdmi_pack.sv
hdmi_display.sv
tb_hdmi_display.sv

/* Makefile */
# Verilator build and run for the camera to HDMI display path

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_hdmi_display
FILELIST := sources.f

SRCS     := $(filter %.sv,$(shell cat $(FILELIST)))
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
